// File: design/cache_pkg.sv
package cache_pkg;

    // data and address width
    localparam int unsigned xlen = 32;
    // set index width
    localparam int unsigned set_bits = 4;
    // byte offset inside a word
    localparam int unsigned offset_bits = 2;
    // whatever is left of the address above index and offset
    localparam int unsigned tag_bits = xlen - set_bits - offset_bits;
    localparam int unsigned num_sets = 2 ** set_bits;

    typedef logic [xlen-1:0] xlen_t;

    // address split as the cache sees it, tag in the upper bits
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    index;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    // same 32 bits, either as a plain word or as tag/index/offset
    typedef union packed {
        xlen_t        word;
        addr_fields_t fields;
    } cache_addr_u;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [tag_bits-1:0] tag;
        xlen_t               data;
    } cache_line_t;

    // lookup result from the line store, all of it for the current index
    typedef struct packed {
        logic                hit;
        logic                hit_way;
        xlen_t               hit_data;
        logic                victim_way;
        logic                victim_valid;
        logic                victim_dirty;
        logic [tag_bits-1:0] victim_tag;
        xlen_t               victim_data;
    } lookup_t;

    // one word-wide request toward main memory
    typedef struct packed {
        logic  valid;
        logic  write;
        xlen_t addr;
        xlen_t wdata;
    } mem_req_t;

endpackage

// File: design/cache_line_store.sv
`timescale 1ns/10ps

module cache_line_store (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  cache_pkg::cache_addr_u lookup_addr_i,
    input  logic                   touch_i,
    input  logic                   write_hit_i,
    input  cache_pkg::xlen_t       wdata_i,
    input  logic                   fill_i,
    input  cache_pkg::xlen_t       fill_data_i,
    input  logic                   fill_dirty_i,
    output cache_pkg::lookup_t     lookup_o
);

    // storage is indexed [way][set]
    logic                           valid_q  [2][cache_pkg::num_sets];
    logic                           dirty_q  [2][cache_pkg::num_sets];
    logic [cache_pkg::tag_bits-1:0] tag_mem  [2][cache_pkg::num_sets];
    cache_pkg::xlen_t               data_mem [2][cache_pkg::num_sets];

    // one bit per set, names the way used last
    logic [cache_pkg::num_sets-1:0] lru_q;

    logic [cache_pkg::set_bits-1:0] idx;
    logic [cache_pkg::tag_bits-1:0] tag;
    cache_pkg::cache_line_t         line [2];
    logic [1:0]                     way_hit;
    logic                           victim_way;

    assign idx = lookup_addr_i.fields.index;
    assign tag = lookup_addr_i.fields.tag;

    // both ways of the addressed set, compared against the request tag
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            line[w].valid = valid_q[w][idx];
            line[w].dirty = dirty_q[w][idx];
            line[w].tag   = tag_mem[w][idx];
            line[w].data  = data_mem[w][idx];
            way_hit[w]    = line[w].valid && (line[w].tag == tag);
        end
    end

    // an empty way is taken first, otherwise the one not used last
    always_comb begin
        if (!line[0].valid) begin
            victim_way = 1'b0;
        end else if (!line[1].valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = ~lru_q[idx];
        end
    end

    always_comb begin
        lookup_o.hit          = |way_hit;
        lookup_o.hit_way      = way_hit[1];
        lookup_o.hit_data     = line[way_hit[1]].data;
        lookup_o.victim_way   = victim_way;
        lookup_o.victim_valid = line[victim_way].valid;
        lookup_o.victim_dirty = line[victim_way].dirty;
        lookup_o.victim_tag   = line[victim_way].tag;
        lookup_o.victim_data  = line[victim_way].data;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lru_q <= '0;
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < cache_pkg::num_sets; s++) begin
                    valid_q[w][s] <= 1'b0;
                    dirty_q[w][s] <= 1'b0;
                end
            end
        end else begin
            if (touch_i) begin
                lru_q[idx] <= lookup_o.hit_way;
            end
            if (write_hit_i) begin
                dirty_q[lookup_o.hit_way][idx] <= 1'b1;
                lru_q[idx]                     <= lookup_o.hit_way;
            end
            // the filled way becomes most recently used
            if (fill_i) begin
                valid_q[lookup_o.victim_way][idx] <= 1'b1;
                dirty_q[lookup_o.victim_way][idx] <= fill_dirty_i;
                lru_q[idx]                        <= lookup_o.victim_way;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_hit_i) begin
            data_mem[lookup_o.hit_way][idx] <= wdata_i;
        end
        if (fill_i) begin
            tag_mem[lookup_o.victim_way][idx]  <= tag;
            data_mem[lookup_o.victim_way][idx] <= fill_data_i;
        end
    end

    // fills only happen after a miss, so one tag never lives in both ways
    a_single_hit: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(way_hit[0] && way_hit[1])
    );

    // the controller issues at most one update command per cycle
    a_fill_vs_write: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(fill_i && write_hit_i)
    );

endmodule

// File: design/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // requester side
    input  logic                   read_i,
    input  logic                   write_i,
    input  cache_pkg::xlen_t       address_i,
    input  cache_pkg::xlen_t       writedata_i,
    output logic                   busy_o,
    output logic                   stb_o,
    output cache_pkg::xlen_t       readdata_o,
    // line store side
    input  cache_pkg::lookup_t     lookup_i,
    output cache_pkg::cache_addr_u lookup_addr_o,
    output logic                   touch_o,
    output logic                   write_hit_o,
    output cache_pkg::xlen_t       wdata_o,
    output logic                   fill_o,
    output cache_pkg::xlen_t       fill_data_o,
    output logic                   fill_dirty_o,
    // main memory side
    output cache_pkg::mem_req_t    mem_req_o,
    input  cache_pkg::xlen_t       mem_rdata_i,
    input  logic                   mem_ack_i
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL,
        INSTALL,
        DONE
    } state_t;

    state_t                 state_q;
    cache_pkg::mem_req_t    mem_req_q;
    cache_pkg::cache_addr_u req_addr_q;
    // write data on a write, the word returned by memory on a read miss
    cache_pkg::xlen_t       data_q;
    cache_pkg::xlen_t       readdata_q;
    logic                   req_write_q;

    logic                   accept;
    logic                   mem_done;
    cache_pkg::cache_addr_u wb_addr;

    // new requests are taken in IDLE and also in the strobe cycle
    assign accept   = ((state_q == IDLE) || (state_q == DONE)) && (read_i || write_i);
    assign mem_done = mem_req_q.valid && mem_ack_i;

    // victim address is its stored tag under the current index
    always_comb begin
        wb_addr.fields.tag    = lookup_i.victim_tag;
        wb_addr.fields.index  = req_addr_q.fields.index;
        wb_addr.fields.offset = '0;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= IDLE;
            mem_req_q <= '0;
        end else begin
            case (state_q)
                IDLE, DONE: begin
                    if (accept) begin
                        state_q <= LOOKUP;
                    end else begin
                        state_q <= IDLE;
                    end
                end
                LOOKUP: begin
                    if (lookup_i.hit) begin
                        state_q <= DONE;
                    end else if (lookup_i.victim_valid && lookup_i.victim_dirty) begin
                        state_q <= WRITEBACK;
                    end else if (req_write_q) begin
                        // write miss installs directly, no memory read
                        state_q <= INSTALL;
                    end else begin
                        state_q <= FILL;
                    end
                end
                WRITEBACK: begin
                    if (!mem_req_q.valid) begin
                        mem_req_q.valid <= 1'b1;
                        mem_req_q.write <= 1'b1;
                        mem_req_q.addr  <= wb_addr.word;
                        mem_req_q.wdata <= lookup_i.victim_data;
                    end else if (mem_ack_i) begin
                        mem_req_q.valid <= 1'b0;
                        state_q         <= req_write_q ? INSTALL : FILL;
                    end
                end
                FILL: begin
                    if (!mem_req_q.valid) begin
                        mem_req_q.valid <= 1'b1;
                        mem_req_q.write <= 1'b0;
                        mem_req_q.addr  <= req_addr_q.word;
                        mem_req_q.wdata <= '0;
                    end else if (mem_ack_i) begin
                        mem_req_q.valid <= 1'b0;
                        state_q         <= INSTALL;
                    end
                end
                INSTALL: begin
                    state_q <= DONE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // request payload and returned data
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_addr_q.word <= address_i;
            req_write_q     <= !read_i;
            data_q          <= writedata_i;
        end
        if ((state_q == FILL) && mem_done) begin
            data_q <= mem_rdata_i;
        end
        if ((state_q == LOOKUP) && lookup_i.hit) begin
            readdata_q <= req_write_q ? '0 : lookup_i.hit_data;
        end
        if (state_q == INSTALL) begin
            readdata_q <= req_write_q ? '0 : data_q;
        end
    end

    assign busy_o     = (state_q != IDLE) && (state_q != DONE);
    assign stb_o      = (state_q == DONE);
    assign readdata_o = readdata_q;

    assign lookup_addr_o = req_addr_q;
    assign touch_o       = (state_q == LOOKUP) && lookup_i.hit && !req_write_q;
    assign write_hit_o   = (state_q == LOOKUP) && lookup_i.hit && req_write_q;
    assign wdata_o       = data_q;
    assign fill_o        = (state_q == INSTALL);
    assign fill_data_o   = data_q;
    // written words go in dirty, fetched words clean
    assign fill_dirty_o  = req_write_q;

    assign mem_req_o = mem_req_q;

    // memory sees a steady request until it acknowledges
    a_mem_req_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (mem_req_q.valid && !mem_ack_i) |=> $stable(mem_req_q)
    );

    a_stb_single: assert property (
        @(posedge clk_i) disable iff (rst_i)
        stb_o |=> !stb_o
    );

    a_idle_no_req: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (state_q == IDLE) |-> !mem_req_q.valid
    );

endmodule

// File: design/cache_top.sv
`timescale 1ns/10ps

module cache_top (
    input  logic                clk_i,
    input  logic                rst_i,
    // requester
    input  logic                read_i,
    input  logic                write_i,
    input  cache_pkg::xlen_t    address_i,
    input  cache_pkg::xlen_t    writedata_i,
    output logic                busy_o,
    output logic                stb_o,
    output cache_pkg::xlen_t    readdata_o,
    // main memory
    output cache_pkg::mem_req_t mem_req_o,
    input  cache_pkg::xlen_t    mem_rdata_i,
    input  logic                mem_ack_i
);

    cache_pkg::cache_addr_u lookup_addr;
    cache_pkg::lookup_t     lookup;
    logic                   touch;
    logic                   write_hit;
    cache_pkg::xlen_t       wdata;
    logic                   fill;
    cache_pkg::xlen_t       fill_data;
    logic                   fill_dirty;

    cache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .read_i        (read_i),
        .write_i       (write_i),
        .address_i     (address_i),
        .writedata_i   (writedata_i),
        .busy_o        (busy_o),
        .stb_o         (stb_o),
        .readdata_o    (readdata_o),
        .lookup_i      (lookup),
        .lookup_addr_o (lookup_addr),
        .touch_o       (touch),
        .write_hit_o   (write_hit),
        .wdata_o       (wdata),
        .fill_o        (fill),
        .fill_data_o   (fill_data),
        .fill_dirty_o  (fill_dirty),
        .mem_req_o     (mem_req_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_ack_i     (mem_ack_i)
    );

    // tag/data array, steered by the controller commands
    cache_line_store u_store (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_addr_i (lookup_addr),
        .touch_i       (touch),
        .write_hit_i   (write_hit),
        .wdata_i       (wdata),
        .fill_i        (fill),
        .fill_data_i   (fill_data),
        .fill_dirty_i  (fill_dirty),
        .lookup_o      (lookup)
    );

endmodule

// File: tb/mem_model.sv
`timescale 1ns/10ps

// main memory stand-in, answers each request after 1 to 4 cycles
module mem_model #(
    parameter cache_pkg::xlen_t init_pattern = '0
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  cache_pkg::mem_req_t req_i,
    output cache_pkg::xlen_t    rdata_o,
    output logic                ack_o,
    output int                  read_count_o,
    output int                  write_count_o,
    output cache_pkg::xlen_t    last_waddr_o,
    output cache_pkg::xlen_t    last_wdata_o
);

    // only written words are kept, all others still read as address ^ pattern
    cache_pkg::xlen_t mem [cache_pkg::xlen_t];
    logic             pending = 1'b0;
    int               cycles_left;

    always @(posedge clk_i) begin
        if (rst_i) begin
            ack_o         <= 1'b0;
            rdata_o       <= '0;
            read_count_o  <= 0;
            write_count_o <= 0;
            last_waddr_o  <= '0;
            last_wdata_o  <= '0;
            pending        = 1'b0;
        end else begin
            ack_o <= 1'b0;
            // no new request is seen in the acknowledge cycle itself
            if (req_i.valid && !ack_o) begin
                if (!pending) begin
                    pending     = 1'b1;
                    cycles_left = $urandom_range(4, 1);
                end
                cycles_left = cycles_left - 1;
                if (cycles_left == 0) begin
                    pending = 1'b0;
                    ack_o  <= 1'b1;
                    if (req_i.write) begin
                        mem[req_i.addr] = req_i.wdata;
                        write_count_o <= write_count_o + 1;
                        last_waddr_o  <= req_i.addr;
                        last_wdata_o  <= req_i.wdata;
                    end else if (mem.exists(req_i.addr)) begin
                        rdata_o      <= mem[req_i.addr];
                        read_count_o <= read_count_o + 1;
                    end else begin
                        rdata_o      <= req_i.addr ^ init_pattern;
                        read_count_o <= read_count_o + 1;
                    end
                end
            end
        end
    end

endmodule

// File: tb/cache_tests.svh
// directed tests, each one starts and ends at a falling edge

task automatic test_reset_and_read_miss();
    cache_pkg::xlen_t addr;
    int               edges;
    int               reads;
    int               writes;
    begin_test("reset_and_read_miss");
    check_true(!busy && !stb && !mem_req.valid, "busy, strobe or memory request high after reset");
    addr   = make_addr(26'd1, 4'd0);
    reads  = mem_reads;
    writes = mem_writes;
    read_check(addr, edges);
    check_equal("memory reads after miss", reads + 1, mem_reads);
    read_check(addr, edges);
    check_equal("hit latency in edges", 2, edges);
    check_equal("memory reads after hit", reads + 1, mem_reads);
    check_equal("memory writes", writes, mem_writes);
    end_test();
endtask

task automatic test_write_hit();
    cache_pkg::xlen_t addr;
    int               edges;
    int               reads;
    int               writes;
    begin_test("write_hit");
    addr   = make_addr(26'd1, 4'd0);
    reads  = mem_reads;
    writes = mem_writes;
    write_word(addr, 32'hcafe_0001);
    read_check(addr, edges);
    check_equal("hit latency in edges", 2, edges);
    // write-back cache, so the new value stays in the line
    check_equal("memory writes", writes, mem_writes);
    check_equal("memory reads", reads, mem_reads);
    end_test();
endtask

task automatic test_dirty_eviction();
    cache_pkg::xlen_t a;
    cache_pkg::xlen_t b;
    cache_pkg::xlen_t c;
    int               edges;
    int               reads;
    int               writes;
    begin_test("dirty_eviction");
    a      = make_addr(26'd2, 4'd1);
    b      = make_addr(26'd3, 4'd1);
    c      = make_addr(26'd4, 4'd1);
    reads  = mem_reads;
    writes = mem_writes;
    write_word(a, 32'h1111_aaaa);
    write_word(b, 32'h2222_bbbb);
    check_equal("memory reads on write misses", reads, mem_reads);
    // a is least recently used, so it goes out first
    read_check(c, edges);
    check_equal("memory writes after eviction", writes + 1, mem_writes);
    check_equal("write-back address", a, last_waddr);
    check_equal("write-back data", 32'h1111_aaaa, last_wdata);
    read_check(a, edges);
    check_equal("memory reads", reads + 2, mem_reads);
    end_test();
endtask

task automatic test_lru_order();
    cache_pkg::xlen_t a;
    cache_pkg::xlen_t b;
    cache_pkg::xlen_t c;
    int               edges;
    int               reads;
    begin_test("lru_order");
    a = make_addr(26'd5, 4'd2);
    b = make_addr(26'd6, 4'd2);
    c = make_addr(26'd7, 4'd2);
    read_check(a, edges);
    read_check(b, edges);
    read_check(a, edges);
    read_check(c, edges);
    reads = mem_reads;
    read_check(a, edges);
    check_equal("latency of a after c", 2, edges);
    check_equal("memory reads for a", reads, mem_reads);
    read_check(b, edges);
    check_equal("memory reads for evicted b", reads + 1, mem_reads);
    end_test();
endtask

task automatic test_random_mix();
    cache_pkg::xlen_t addr;
    int               edges;
    begin_test("random_mix");
    for (int i = 0; i < 200; i++) begin
        // four tags over four sets keep both ways busy and evicting
        addr = make_addr(26'($urandom_range(4, 1)), 4'($urandom_range(11, 8)));
        if ($urandom_range(1, 0) == 1) begin
            write_word(addr, $urandom());
        end else begin
            read_check(addr, edges);
        end
    end
    end_test();
endtask

// File: tb/tb_cache_top.sv
`timescale 1ns/10ps

module tb_cache_top;

    localparam cache_pkg::xlen_t init_pattern = 32'ha5c3_0f69;
    localparam int               seed         = 32'h6ffe;
    // about four times the longest expected run
    localparam int               max_cycles   = 4000;

    logic                clk;
    logic                rst;
    logic                read_req;
    logic                write_req;
    cache_pkg::xlen_t    address;
    cache_pkg::xlen_t    writedata;
    logic                busy;
    logic                stb;
    cache_pkg::xlen_t    readdata;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::xlen_t    mem_rdata;
    logic                mem_ack;
    int                  mem_reads;
    int                  mem_writes;
    cache_pkg::xlen_t    last_waddr;
    cache_pkg::xlen_t    last_wdata;

    // expected contents, by address, of everything written so far
    cache_pkg::xlen_t    shadow [cache_pkg::xlen_t];
    string               test_name;
    int                  test_errors;
    int                  tests_passed = 0;
    int                  tests_failed = 0;
    int                  cycle_count  = 0;

    cache_top u_dut (
        .clk_i       (clk),
        .rst_i       (rst),
        .read_i      (read_req),
        .write_i     (write_req),
        .address_i   (address),
        .writedata_i (writedata),
        .busy_o      (busy),
        .stb_o       (stb),
        .readdata_o  (readdata),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata),
        .mem_ack_i   (mem_ack)
    );

    mem_model #(
        .init_pattern (init_pattern)
    ) u_mem (
        .clk_i         (clk),
        .rst_i         (rst),
        .req_i         (mem_req),
        .rdata_o       (mem_rdata),
        .ack_o         (mem_ack),
        .read_count_o  (mem_reads),
        .write_count_o (mem_writes),
        .last_waddr_o  (last_waddr),
        .last_wdata_o  (last_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic cache_pkg::xlen_t make_addr(input logic [25:0] tag,
                                                   input logic [3:0]  index);
        return {tag, index, 2'b00};
    endfunction

    // last written value, or what memory held from the start
    function automatic cache_pkg::xlen_t expected_at(input cache_pkg::xlen_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ init_pattern;
    endfunction

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
            tests_passed++;
        end else begin
            $display("%s: %0d check(s) failed", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic check_equal(input string what, input cache_pkg::xlen_t expected,
                               input cache_pkg::xlen_t actual);
        assert (actual == expected) else begin
            $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string msg);
        assert (ok) else begin
            $display("error in %s: %s", test_name, msg);
            test_errors++;
        end
    endtask

    // one request, returns the read data and the edges from acceptance to strobe
    task automatic access(input logic is_write, input cache_pkg::xlen_t addr,
                          input cache_pkg::xlen_t wdata, output cache_pkg::xlen_t rdata,
                          output int edges);
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        read_req  = !is_write;
        write_req = is_write;
        address   = addr;
        writedata = wdata;
        @(posedge clk);
        edges = 1;
        @(negedge clk);
        read_req  = 1'b0;
        write_req = 1'b0;
        address   = '0;
        writedata = '0;
        check_true(busy, "busy_o did not rise after the request was accepted");
        while (!stb) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        rdata = readdata;
    endtask

    task automatic write_word(input cache_pkg::xlen_t addr, input cache_pkg::xlen_t value);
        cache_pkg::xlen_t rdata;
        int               edges;
        access(1'b1, addr, value, rdata, edges);
        shadow[addr] = value;
        check_equal("read data on a write", '0, rdata);
    endtask

    task automatic read_check(input cache_pkg::xlen_t addr, output int edges);
        cache_pkg::xlen_t rdata;
        access(1'b0, addr, '0, rdata, edges);
        check_equal($sformatf("read data at %h", addr), expected_at(addr), rdata);
    endtask

    `include "cache_tests.svh"

    initial begin
        void'($urandom(seed));
        rst       = 1'b1;
        read_req  = 1'b0;
        write_req = 1'b0;
        address   = '0;
        writedata = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_and_read_miss();
        test_write_hit();
        test_dirty_eviction();
        test_lru_order();
        test_random_mix();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
design/cache_pkg.sv
design/cache_line_store.sv
design/cache_ctrl.sv
design/cache_top.sv
tb/mem_model.sv
tb/tb_cache_top.sv
+incdir+tb
